// ==== source/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 64
`define LINE_WORDS  4

// read bus
`define BUS_ADDR_W  32
`define BURST_LEN   (`LINE_WORDS - 1)  // len field of a line refill

`endif

// ==== source/cache_pkg.sv ====
`include "cache_settings.svh"

package cache_pkg;

    // address split: tag | index | offset
    localparam int OFFSET_W = $clog2(`LINE_WORDS * 4);
    localparam int INDEX_W  = $clog2(`ICACHE_SETS);
    localparam int TAG_W    = `BUS_ADDR_W - INDEX_W - OFFSET_W;

    // one cache line in bits
    localparam int LINE_W   = `LINE_WORDS * 32;

    // exception codes reported with a fetch
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = 7'h08   // fetch address error
    } exc_code_t;

    // icache controller states
    typedef enum logic [2:0] {
        IDLE,       // ready for a new fetch or cacop
        LOOKUP,     // tag compare on the registered read
        MISS_REQ,   // line request on the bus
        REFILL,     // collecting burst beats
        UNC_REQ,    // single word request
        UNC_WAIT,   // waiting for the single beat
        CACOP       // set invalidate
    } icache_state_t;

endpackage

// ==== source/mem_bus_if.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

interface mem_bus_if;

    logic                   req;        // held until rdy
    logic [`BUS_ADDR_W-1:0] addr;
    logic [7:0]             len;        // beats minus one
    logic                   rdy;
    logic                   ret_valid;
    logic                   ret_last;   // marks the final beat
    logic [31:0]            ret_data;

    modport requester (
        output req,
        output addr,
        output len,
        input  rdy,
        input  ret_valid,
        input  ret_last,
        input  ret_data
    );

    modport memory (
        input  req,
        input  addr,
        input  len,
        output rdy,
        output ret_valid,
        output ret_last,
        output ret_data
    );

endinterface

// ==== source/icache_tagv.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_tagv
    import cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [INDEX_W-1:0]      rd_index,
    input  logic [TAG_W-1:0]        cmp_tag,
    input  logic [`ICACHE_WAYS-1:0] wr_en,
    input  logic [INDEX_W-1:0]      wr_index,
    input  logic [TAG_W-1:0]        wr_tag,
    input  logic                    inv_en,
    output logic [`ICACHE_WAYS-1:0] hit_way
);

    logic [TAG_W-1:0]                          tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
    logic [TAG_W-1:0]                          rd_tag_q [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]                   rd_valid_q;

    // tag storage, synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (wr_en[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            rd_tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits cleared on reset and by invalidate
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            rd_valid_q <= '0;
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (inv_en) begin
                    valid_q[w][wr_index] <= 1'b0;     // whole set, every way
                end else if (wr_en[w]) begin
                    valid_q[w][wr_index] <= 1'b1;
                end
                rd_valid_q[w] <= valid_q[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag);
        end
    end

endmodule

// ==== source/icache_data.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_data
    import cache_pkg::*;
(
    input  logic                                clk,
    input  logic [INDEX_W-1:0]                  rd_index,
    input  logic [`ICACHE_WAYS-1:0]             wr_en,
    input  logic [INDEX_W-1:0]                  wr_index,
    input  logic [LINE_W-1:0]                   wr_line,
    output logic [`ICACHE_WAYS-1:0][LINE_W-1:0] rd_lines
);

    // one full line per way per set
    logic [LINE_W-1:0] line_mem [`ICACHE_WAYS][`ICACHE_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (wr_en[w]) begin
                line_mem[w][wr_index] <= wr_line;   // whole line from refill
            end
            rd_lines[w] <= line_mem[w][rd_index];   // old data on a collision
        end
    end

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   fetch_valid,
    input  logic [`BUS_ADDR_W-1:0] fetch_pc,
    input  logic                   fetch_uncache,
    input  logic                   cacop_en,
    output logic                   fetch_ready,
    output logic                   fetch_data_valid,
    output logic [31:0]            fetch_inst,
    output exc_code_t              fetch_exc,
    output logic                   cacop_complete,
    mem_bus_if.requester           bus
);

    icache_state_t                      state_q;
    icache_state_t                      state_d;
    logic [`BUS_ADDR_W-1:0]             pc_q;        // request buffer
    logic                               unc_q;
    logic [LINE_W-1:0]                  refill_q;    // refill buffer
    logic [LINE_W-1:0]                  fill_line;
    logic [LINE_W-1:0]                  hit_line;
    logic [`ICACHE_WAYS-1:0][LINE_W-1:0] rd_lines;
    logic [`ICACHE_WAYS-1:0]            hit_way;
    logic [`ICACHE_WAYS-1:0]            fill_we;
    logic [`ICACHE_SETS-1:0]            lru_q;       // way not used most recently
    logic [INDEX_W-1:0]                 index;
    logic [TAG_W-1:0]                   tag;
    logic [OFFSET_W-3:0]                word_sel;
    logic                               hit;
    logic                               misaligned;
    logic                               lookup_done;
    logic                               lookup_hit;
    logic                               fill_done;
    logic                               unc_done;
    logic                               data_valid_q;
    logic                               cacop_done_q;
    logic [31:0]                        inst_q;
    exc_code_t                          exc_q;

    assign index      = pc_q[OFFSET_W +: INDEX_W];
    assign tag        = pc_q[`BUS_ADDR_W-1 -: TAG_W];
    assign word_sel   = pc_q[OFFSET_W-1:2];
    assign hit        = |hit_way;
    assign misaligned = (pc_q[1:0] != 2'b00);

    assign lookup_done = (state_q == LOOKUP) && (misaligned || (!unc_q && hit));
    assign lookup_hit  = (state_q == LOOKUP) && !misaligned && !unc_q && hit;
    assign fill_done   = (state_q == REFILL) && bus.ret_valid && bus.ret_last;
    assign unc_done    = (state_q == UNC_WAIT) && bus.ret_valid && bus.ret_last;

    // last beat joins the buffered ones, word 0 ends up lowest
    assign fill_line = {bus.ret_data, refill_q[LINE_W-1:32]};
    assign fill_we   = fill_done ? (`ICACHE_WAYS'(1) << lru_q[index]) : '0;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_way[w]) hit_line = hit_line | rd_lines[w];
        end
    end

    icache_tagv u_tagv (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_index (fetch_pc[OFFSET_W +: INDEX_W]),
        .cmp_tag  (tag),
        .wr_en    (fill_we),
        .wr_index (index),
        .wr_tag   (tag),
        .inv_en   (state_q == CACOP),
        .hit_way  (hit_way)
    );

    icache_data u_data (
        .clk      (clk),
        .rd_index (fetch_pc[OFFSET_W +: INDEX_W]),
        .wr_en    (fill_we),
        .wr_index (index),
        .wr_line  (fill_line),
        .rd_lines (rd_lines)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cacop_en) state_d = CACOP;        // cacop recorded in the state
                else if (fetch_valid) state_d = LOOKUP;
            end
            LOOKUP: begin
                if (lookup_done) state_d = IDLE;
                else if (unc_q) state_d = UNC_REQ;
                else state_d = MISS_REQ;
            end
            MISS_REQ: if (bus.rdy) state_d = REFILL;
            REFILL:   if (fill_done) state_d = IDLE;
            UNC_REQ:  if (bus.rdy) state_d = UNC_WAIT;
            UNC_WAIT: if (unc_done) state_d = IDLE;
            default:  state_d = IDLE;                 // CACOP takes one cycle
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= IDLE;
            data_valid_q <= 1'b0;
            cacop_done_q <= 1'b0;
            lru_q        <= '0;
        end else begin
            state_q      <= state_d;
            data_valid_q <= lookup_done || fill_done || unc_done;
            cacop_done_q <= (state_q == CACOP);
            if (lookup_hit) lru_q[index] <= hit_way[0];
            else if (fill_done) lru_q[index] <= ~lru_q[index];  // filled way now newest
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready && (fetch_valid || cacop_en)) begin
            pc_q  <= fetch_pc;
            unc_q <= fetch_uncache;
        end
        if ((state_q == REFILL) && bus.ret_valid) refill_q <= fill_line;
        if (lookup_done) begin
            inst_q <= misaligned ? 32'h0 : hit_line[word_sel*32 +: 32];
            exc_q  <= misaligned ? EXC_ADEF : EXC_NONE;
        end else if (fill_done) begin
            inst_q <= fill_line[word_sel*32 +: 32];
            exc_q  <= EXC_NONE;
        end else if (unc_done) begin
            inst_q <= bus.ret_data;
            exc_q  <= EXC_NONE;
        end
    end

    assign bus.req  = (state_q == MISS_REQ) || (state_q == UNC_REQ);
    assign bus.addr = unc_q ? {pc_q[`BUS_ADDR_W-1:2], 2'b00}
                            : {pc_q[`BUS_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign bus.len  = unc_q ? 8'd0 : 8'(`BURST_LEN);

    assign fetch_ready      = (state_q == IDLE);
    assign fetch_data_valid = data_valid_q;
    assign fetch_inst       = inst_q;
    assign fetch_exc        = exc_q;
    assign cacop_complete   = cacop_done_q;

endmodule

// ==== source/data_port.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

module data_port (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load_valid,
    input  logic [`BUS_ADDR_W-1:0] load_addr,
    output logic                   load_ready,
    output logic                   load_data_valid,
    output logic [31:0]            load_data,
    mem_bus_if.requester           bus
);

    logic                   busy_q;     // load in flight
    logic                   req_q;      // request not yet accepted
    logic                   valid_q;
    logic                   done;
    logic [`BUS_ADDR_W-1:0] addr_q;
    logic [31:0]            data_q;

    assign done = busy_q && !req_q && bus.ret_valid && bus.ret_last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            req_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (load_valid && load_ready) begin
                busy_q <= 1'b1;
                req_q  <= 1'b1;
            end else begin
                if (req_q && bus.rdy) req_q <= 1'b0;
                if (done) busy_q <= 1'b0;
            end
            valid_q <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid && load_ready) addr_q <= {load_addr[`BUS_ADDR_W-1:2], 2'b00};
        if (done) data_q <= bus.ret_data;
    end

    assign bus.req  = req_q;
    assign bus.addr = addr_q;
    assign bus.len  = 8'd0;             // always a single word

    assign load_ready      = !busy_q;
    assign load_data_valid = valid_q;
    assign load_data       = data_q;

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   arst_n,
    mem_bus_if.memory              icache_bus,
    mem_bus_if.memory              dport_bus,
    output logic                   rd_req,
    output logic [`BUS_ADDR_W-1:0] rd_addr,
    output logic [7:0]             rd_len,
    input  logic                   rd_rdy,
    input  logic                   rd_ret_valid,
    input  logic                   rd_ret_last,
    input  logic [31:0]            rd_ret_data
);

    logic busy_q;   // grant held until ret_last
    logic last_q;   // last granted, 0 icache 1 data port
    logic pick;
    logic sel;

    // round robin on a tie
    always_comb begin
        if (icache_bus.req && dport_bus.req) pick = ~last_q;
        else pick = dport_bus.req;
    end

    assign sel = busy_q ? last_q : pick;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            last_q <= 1'b1;                 // icache wins the first tie
        end else if (!busy_q) begin
            if (icache_bus.req || dport_bus.req) begin
                busy_q <= 1'b1;
                last_q <= pick;
            end
        end else if (rd_ret_valid && rd_ret_last) begin
            busy_q <= 1'b0;
        end
    end

    assign rd_req  = sel ? dport_bus.req  : icache_bus.req;
    assign rd_addr = sel ? dport_bus.addr : icache_bus.addr;
    assign rd_len  = sel ? dport_bus.len  : icache_bus.len;

    // loser sees rdy low
    assign icache_bus.rdy = !sel && rd_rdy;
    assign dport_bus.rdy  = sel && rd_rdy;

    // beats go only to the owner
    assign icache_bus.ret_valid = busy_q && !last_q && rd_ret_valid;
    assign icache_bus.ret_last  = busy_q && !last_q && rd_ret_last;
    assign icache_bus.ret_data  = rd_ret_data;
    assign dport_bus.ret_valid  = busy_q && last_q && rd_ret_valid;
    assign dport_bus.ret_last   = busy_q && last_q && rd_ret_last;
    assign dport_bus.ret_data   = rd_ret_data;

endmodule

// ==== source/fetch_subsystem.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

module fetch_subsystem
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    // fetch side
    input  logic                   fetch_valid,
    input  logic [`BUS_ADDR_W-1:0] fetch_pc,
    input  logic                   fetch_uncache,
    input  logic                   cacop_en,
    output logic                   fetch_ready,
    output logic                   fetch_data_valid,
    output logic [31:0]            fetch_inst,
    output exc_code_t              fetch_exc,
    output logic                   cacop_complete,
    // load side
    input  logic                   load_valid,
    input  logic [`BUS_ADDR_W-1:0] load_addr,
    output logic                   load_ready,
    output logic                   load_data_valid,
    output logic [31:0]            load_data,
    // shared read bus
    output logic                   rd_req,
    output logic [`BUS_ADDR_W-1:0] rd_addr,
    output logic [7:0]             rd_len,
    input  logic                   rd_rdy,
    input  logic                   rd_ret_valid,
    input  logic                   rd_ret_last,
    input  logic [31:0]            rd_ret_data
);

    mem_bus_if icache_bus ();
    mem_bus_if dport_bus ();

    icache u_icache (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_uncache    (fetch_uncache),
        .cacop_en         (cacop_en),
        .fetch_ready      (fetch_ready),
        .fetch_data_valid (fetch_data_valid),
        .fetch_inst       (fetch_inst),
        .fetch_exc        (fetch_exc),
        .cacop_complete   (cacop_complete),
        .bus              (icache_bus.requester)
    );

    data_port u_data_port (
        .clk             (clk),
        .arst_n          (arst_n),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_ready      (load_ready),
        .load_data_valid (load_data_valid),
        .load_data       (load_data),
        .bus             (dport_bus.requester)
    );

    bus_arbiter u_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .icache_bus   (icache_bus.memory),
        .dport_bus    (dport_bus.memory),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_len       (rd_len),
        .rd_rdy       (rd_rdy),
        .rd_ret_valid (rd_ret_valid),
        .rd_ret_last  (rd_ret_last),
        .rd_ret_data  (rd_ret_data)
    );

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // observed DUT signals
    input  logic        fetch_valid,
    input  logic        fetch_ready,
    input  logic        cacop_en,
    input  logic        fetch_data_valid,
    input  logic [31:0] fetch_inst,
    input  exc_code_t   fetch_exc,
    input  logic        cacop_complete,
    input  logic        load_data_valid,
    input  logic [31:0] load_data,
    // expected values from the vector reader
    input  logic [31:0] exp_inst,
    input  exc_code_t   exp_exc,
    input  logic        exp_fast,
    input  logic [31:0] exp_load,
    input  logic        chk_bursts,
    input  logic        chk_words,
    input  int          exp_lines,
    input  int          exp_words,
    // burst counts from the memory model
    input  int          line_bursts,
    input  int          word_bursts,
    output int          errors,
    output int          fetch_seen,
    output int          cacop_seen,
    output int          load_seen
);

    int cyc;
    int acc_cyc;    // cycle of the last accepted fetch or cacop

    initial begin
        errors     = 0;
        fetch_seen = 0;
        cacop_seen = 0;
        load_seen  = 0;
        cyc        = 0;
        acc_cyc    = 0;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cyc = cyc + 1;
            if (fetch_ready && (fetch_valid || cacop_en)) acc_cyc = cyc;
            if (fetch_data_valid) begin
                fetch_seen = fetch_seen + 1;
                if (fetch_inst !== exp_inst) begin
                    $display("[ERROR] fetch_inst: got %h, expected %h", fetch_inst, exp_inst);
                    errors = errors + 1;
                end
                if (fetch_exc !== exp_exc) begin
                    $display("[ERROR] fetch_exc: got %h, expected %h", fetch_exc, exp_exc);
                    errors = errors + 1;
                end
                if (exp_fast && (cyc - acc_cyc != 2)) begin
                    $display("[ERROR] fetch latency: got %h, expected %h", cyc - acc_cyc, 2);
                    errors = errors + 1;
                end
            end
            if (cacop_complete) begin
                cacop_seen = cacop_seen + 1;
                if (cyc - acc_cyc != 2) begin
                    $display("[ERROR] cacop latency: got %h, expected %h", cyc - acc_cyc, 2);
                    errors = errors + 1;
                end
            end
            if (load_data_valid) begin
                load_seen = load_seen + 1;
                if (load_data !== exp_load) begin
                    $display("[ERROR] load_data: got %h, expected %h", load_data, exp_load);
                    errors = errors + 1;
                end
            end
            if (chk_bursts && (line_bursts != exp_lines)) begin
                $display("[ERROR] line bursts: got %h, expected %h", line_bursts, exp_lines);
                errors = errors + 1;
            end
            if (chk_bursts && chk_words && (word_bursts != exp_words)) begin
                $display("[ERROR] word bursts: got %h, expected %h", word_bursts, exp_words);
                errors = errors + 1;
            end
        end
    end

endmodule

// ==== test/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
    import cache_pkg::*;
();

    logic        clk           = 1'b0;
    logic        arst_n        = 1'b0;
    logic        fetch_valid   = 1'b0;
    logic [31:0] fetch_pc      = 32'h0;
    logic        fetch_uncache = 1'b0;
    logic        cacop_en      = 1'b0;
    logic        load_valid    = 1'b0;
    logic [31:0] load_addr     = 32'h0;
    logic        rd_rdy        = 1'b0;
    logic        rd_ret_valid  = 1'b0;
    logic        rd_ret_last   = 1'b0;
    logic [31:0] rd_ret_data   = 32'h0;
    logic        fetch_ready;
    logic        fetch_data_valid;
    logic [31:0] fetch_inst;
    exc_code_t   fetch_exc;
    logic        cacop_complete;
    logic        load_ready;
    logic        load_data_valid;
    logic [31:0] load_data;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic [7:0]  rd_len;

    logic [31:0] exp_inst   = 32'h0;
    exc_code_t   exp_exc    = EXC_NONE;
    logic        exp_fast   = 1'b0;
    logic [31:0] exp_load   = 32'h0;
    logic        chk_bursts = 1'b0;
    logic        chk_words  = 1'b0;
    int          exp_lines  = 0;
    int          exp_words  = 0;
    int          errors;
    int          fetch_seen;
    int          cacop_seen;
    int          load_seen;
    int          loads_issued   = 0;
    int          fetches_issued = 0;
    int          cacops_issued  = 0;
    int          timeouts       = 0;
    int          other_errors   = 0;

    // memory model state
    logic [1:0]  mstate      = 2'd0;
    logic [1:0]  delay       = 2'd0;
    logic [31:0] seed        = 32'hf6f61afb;
    logic [31:0] base        = 32'h0;
    logic [7:0]  blen        = 8'd0;
    logic [7:0]  beat        = 8'd0;
    int          line_bursts = 0;
    int          word_bursts = 0;
    int          bad_bursts  = 0;

    fetch_subsystem i_dut (.*);

    tb_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:16] ^ 16'hc3a5, a[15:0]};
    endfunction

    // random accept delay, then len+1 beats
    always @(negedge clk) begin
        if (arst_n) begin
            case (mstate)
                2'd0: if (rd_req) begin
                    seed   = lcg_next(seed);
                    delay  = seed[17:16];
                    mstate = 2'd1;
                end
                2'd1: if (delay == 2'd0) begin
                    rd_rdy = 1'b1;
                    mstate = 2'd2;
                end else begin
                    delay = delay - 2'd1;
                end
                2'd2: begin                                 // accepted on the last edge
                    rd_rdy = 1'b0;
                    base   = rd_addr;
                    blen   = rd_len;
                    beat   = 8'd0;
                    if (rd_len == 8'd3) line_bursts = line_bursts + 1;
                    else if (rd_len == 8'd0) word_bursts = word_bursts + 1;
                    else begin
                        $display("[ERROR] rd_len: got %h, expected 00 or 03", rd_len);
                        bad_bursts = bad_bursts + 1;
                    end
                    rd_ret_valid = 1'b1;
                    rd_ret_data  = mem_word(base);
                    rd_ret_last  = (blen == 8'd0);
                    mstate       = 2'd3;
                end
                default: if (beat == blen) begin
                    rd_ret_valid = 1'b0;
                    rd_ret_last  = 1'b0;
                    mstate       = 2'd0;
                end else begin
                    beat         = beat + 8'd1;
                    rd_ret_data  = mem_word(base + 32'(beat) * 32'd4);
                    rd_ret_last  = (beat == blen);
                end
            endcase
        end
    end

    function automatic logic condition_met(input int what, input int target);
        case (what)
            0:       return fetch_ready;
            1:       return fetch_seen >= target;
            2:       return cacop_seen >= target;
            default: return load_ready && (load_seen >= target);
        endcase
    endfunction

    task automatic wait_until(input int what, input int target);
        int n;
        n = 0;
        while (!condition_met(what, target) && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!condition_met(what, target)) begin
            $display("timed out waiting for the DUT, wait kind %0d", what);
            timeouts++;
        end
    endtask

    task automatic check_bursts();
        chk_words  = load_ready && (load_seen == loads_issued);  // no load in flight
        chk_bursts = 1'b1;
        @(negedge clk);
        chk_bursts = 1'b0;
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] addr,
                          input logic [31:0] word, input int nl, input int nw);
        int target;
        exp_lines = exp_lines + nl;
        exp_words = exp_words + nw;
        if (op == "L") begin
            wait_until(3, loads_issued);
            exp_load   = word;
            load_addr  = addr;
            load_valid = 1'b1;
            @(posedge clk);
            @(negedge clk);
            load_valid   = 1'b0;
            loads_issued = loads_issued + 1;
        end else begin
            wait_until(0, 0);
            fetch_pc = addr;
            if (op == "C") begin
                target        = cacop_seen + 1;
                cacop_en      = 1'b1;
                cacops_issued = cacops_issued + 1;
            end else begin
                target         = fetch_seen + 1;
                exp_inst       = word;
                exp_exc        = (addr[1:0] != 2'b00) ? EXC_ADEF : EXC_NONE;
                exp_fast       = (op == "F" && nl == 0) || (addr[1:0] != 2'b00);
                fetch_uncache  = (op == "U");
                fetch_valid    = 1'b1;
                fetches_issued = fetches_issued + 1;
            end
            @(posedge clk);
            @(negedge clk);
            fetch_valid = 1'b0;
            cacop_en    = 1'b0;
            wait_until((op == "C") ? 2 : 1, target);
            check_bursts();
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          nl;
        int          nw;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] word;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fd = $fopen("test/fetch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 3 || line[0] == "#") continue;
                code = $sscanf(line, "%c %h %h %d %d", op, addr, word, nl, nw);
                if (code != 5) begin
                    $display("a vector line has fewer than five fields");
                    other_errors++;
                    continue;
                end
                run_op(op, addr, word, nl, nw);
            end
            $fclose(fd);
        end
        wait_until(3, loads_issued);        // drain the last load
        check_bursts();
        repeat (2) @(negedge clk);
        if (fetch_seen != fetches_issued || cacop_seen != cacops_issued
                || load_seen != loads_issued) begin
            $display("the DUT gave a different number of responses than requests issued");
            other_errors++;
        end
        $display("errors: check %0d, timeout %0d, bus %0d, other %0d",
                 errors, timeouts, bad_bursts, other_errors);
        if (errors + timeouts + bad_bursts + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/fetch_vectors.txt ====
# op (F fetch, U uncached, C cacop, L load), address, expected word,
# line bursts caused, word bursts caused
F 00001020 c3a51020 1 0
F 0000102c c3a5102c 0 0
F 00001424 c3a51424 1 0
F 00001028 c3a51028 0 0
F 00001828 c3a51828 1 0
F 00001024 c3a51024 0 0
F 00001420 c3a51420 1 0
U 00002040 c3a52040 0 1
U 00002044 c3a52044 0 1
F 00002040 c3a52040 1 0
F 00002048 c3a52048 0 0
U 00001020 c3a51020 0 1
F 00003002 00000000 0 0
F 00001021 00000000 0 0
U 00001026 00000000 0 0
C 00001020 00000000 0 0
F 0000102c c3a5102c 1 0
F 00001428 c3a51428 1 0
F 0000102c c3a5102c 0 0
L 12340100 d1910100 0 1
F 0000a0c0 c3a5a0c0 1 0
L 89ab0ff4 4a0e0ff4 0 1
F 00ff0330 c35a0330 1 0
L 7ffffffc bc5afffc 0 1
F 7fff0504 bc5a0504 1 0
L 00004000 c3a54000 0 1
U 00005000 c3a55000 0 1
F 0000a0c8 c3a5a0c8 0 0

// ==== compile.f ====
+incdir+source
source/cache_pkg.sv
source/mem_bus_if.sv
source/icache_tagv.sv
source/icache_data.sv
source/icache.sv
source/data_port.sv
source/bus_arbiter.sv
source/fetch_subsystem.sv
test/tb_checker.sv
test/tb_fetch.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the fetch subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module tb_fetch -Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
